// File: verilog/mpq_pkg.sv
/* mpq engine package: field widths, packet and header-event records,
   handler kind and queue state enums, handler task and slice request */
package mpq_pkg;

    localparam int ADDR_W  = 32;
    localparam int SIZE_W  = 16;
    localparam int MSGID_W = 8;

    typedef struct packed {
        logic [ADDR_W-1:0] pkt_addr;
        logic [SIZE_W-1:0] pkt_size;
    } pkt_t;

    // handler addresses are only taken from the first her of a message
    typedef struct packed {
        logic [MSGID_W-1:0] msgid;
        logic               eom;
        pkt_t               pkt;
        logic [ADDR_W-1:0]  hh_addr;
        logic [ADDR_W-1:0]  ph_addr;
        logic [ADDR_W-1:0]  th_addr;
    } her_t;

    typedef enum logic [1:0] {
        HDR,
        PAY,
        CMP
    } handler_kind_e;

    typedef struct packed {
        logic [MSGID_W-1:0] msgid;
        handler_kind_e      kind;
        logic [ADDR_W-1:0]  handler_addr;
        pkt_t               pkt;
    } task_t;

    typedef enum logic [2:0] {
        FREE,
        HEADER,
        HEADER_RUN,
        PAYLOAD,
        DRAINING,
        COMPLETION,
        COMPLETION_RUN
    } mpq_state_e;

    // task offered by one queue to the scheduler
    typedef struct packed {
        logic  valid;
        task_t tsk;
    } slice_req_t;

endpackage

// File: verilog/her_dispatch.sv
/* her and feedback dispatch: queue index decode, her ready gating,
   one-hot push and feedback strobes */
module her_dispatch import mpq_pkg::*; #(
    parameter int NUM_MPQ = 8
) (
    input  logic               her_valid_i,
    input  her_t               her_i,
    output logic               her_ready_o,
    input  logic               feedback_valid_i,
    input  logic [MSGID_W-1:0] feedback_msgid_i,
    input  logic [NUM_MPQ-1:0] full_i,
    output logic [NUM_MPQ-1:0] push_o,
    output logic [NUM_MPQ-1:0] feedback_o
);

    localparam int IDX_W = (NUM_MPQ > 1) ? $clog2(NUM_MPQ) : 1;

    logic [IDX_W-1:0] her_idx;
    logic [IDX_W-1:0] fb_idx;

    // low msgid bits pick the queue
    assign her_idx = her_i.msgid[IDX_W-1:0];
    assign fb_idx  = feedback_msgid_i[IDX_W-1:0];

    // only the addressed queue's fifo matters, valid is not looked at
    assign her_ready_o = !full_i[her_idx];

    always_comb begin
        push_o     = '0;
        feedback_o = '0;
        if (her_valid_i && her_ready_o) begin
            push_o[her_idx] = 1'b1;
        end
        // feedback is always taken
        if (feedback_valid_i) begin
            feedback_o[fb_idx] = 1'b1;
        end
    end

endmodule

// File: verilog/mpq_slice.sv
/* one message queue: packet fifo, handler metadata, length and in-flight
   counters, eom tracking and the header/payload/completion FSM */
module mpq_slice import mpq_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       push_i,
    input  her_t       her_i,
    input  logic       feedback_i,
    input  logic       grant_i,
    output logic       full_o,
    output slice_req_t req_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int LEN_W = $clog2(FIFO_DEPTH + 1);
    localparam int IFL_W = 8;

    mpq_state_e       state_q, state_d;
    pkt_t             fifo_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [LEN_W-1:0] length_q, length_d;
    logic [IFL_W-1:0] inflight_q, inflight_d;
    logic             eom_seen_q, eom_seen_d;
    logic             pop;
    logic             empty;

    // metadata of the message that owns the queue
    logic [MSGID_W-1:0] msgid_q;
    logic [ADDR_W-1:0]  hh_addr_q, ph_addr_q, th_addr_q;

    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty  = (length_q == '0);
    assign full_o = (length_q == LEN_W'(FIFO_DEPTH));
    // header tasks leave the head packet in place
    assign pop    = grant_i && (state_q == PAYLOAD);

    always_comb begin
        length_d = length_q;
        if (push_i && !pop) begin
            length_d = length_q + 1'b1;
        end else if (pop && !push_i) begin
            length_d = length_q - 1'b1;
        end
    end

    always_comb begin
        inflight_d = inflight_q;
        if (grant_i && !feedback_i) begin
            inflight_d = inflight_q + 1'b1;
        end else if (feedback_i && !grant_i) begin
            inflight_d = inflight_q - 1'b1;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            FREE: begin
                if (push_i) begin
                    state_d = (her_i.hh_addr != '0) ? HEADER : PAYLOAD;
                end
            end
            HEADER: begin
                if (grant_i) begin
                    state_d = HEADER_RUN;
                end
            end
            HEADER_RUN: begin
                if (feedback_i) begin
                    state_d = PAYLOAD;
                end
            end
            PAYLOAD: begin
                // last packet of the message leaves the fifo
                if (pop && eom_seen_q && length_q == LEN_W'(1)) begin
                    state_d = DRAINING;
                end
            end
            DRAINING: begin
                if (feedback_i && inflight_d == '0) begin
                    state_d = (th_addr_q != '0) ? COMPLETION : FREE;
                end
            end
            COMPLETION: begin
                if (grant_i) begin
                    state_d = COMPLETION_RUN;
                end
            end
            COMPLETION_RUN: begin
                if (feedback_i) begin
                    state_d = FREE;
                end
            end
            default: state_d = FREE;
        endcase
    end

    always_comb begin
        eom_seen_d = eom_seen_q;
        if (push_i && her_i.eom) begin
            eom_seen_d = 1'b1;
        end
        if (state_d == FREE) begin
            eom_seen_d = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= FREE;
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            length_q   <= '0;
            inflight_q <= '0;
            eom_seen_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            length_q   <= length_d;
            inflight_q <= inflight_d;
            eom_seen_q <= eom_seen_d;
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            fifo_mem[wr_ptr_q] <= her_i.pkt;
        end
        // first her of a message carries the handlers
        if (push_i && state_q == FREE) begin
            msgid_q   <= her_i.msgid;
            hh_addr_q <= her_i.hh_addr;
            ph_addr_q <= her_i.ph_addr;
            th_addr_q <= her_i.th_addr;
        end
    end

    always_comb begin
        req_o           = '0;
        req_o.tsk.msgid = msgid_q;
        case (state_q)
            HEADER: begin
                req_o.valid            = !empty;
                req_o.tsk.kind         = HDR;
                req_o.tsk.handler_addr = hh_addr_q;
                req_o.tsk.pkt          = fifo_mem[rd_ptr_q];
            end
            PAYLOAD: begin
                req_o.valid            = !empty;
                req_o.tsk.kind         = PAY;
                req_o.tsk.handler_addr = ph_addr_q;
                req_o.tsk.pkt          = fifo_mem[rd_ptr_q];
            end
            COMPLETION: begin
                // completion runs without a packet
                req_o.valid            = 1'b1;
                req_o.tsk.kind         = CMP;
                req_o.tsk.handler_addr = th_addr_q;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: verilog/task_scheduler.sv
/* round-robin queue selection, grant generation and the task output
   register that holds under back-pressure */
module task_scheduler import mpq_pkg::*; #(
    parameter int NUM_MPQ = 8
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  slice_req_t [NUM_MPQ-1:0] req_i,
    output logic [NUM_MPQ-1:0]       grant_o,
    input  logic                     task_ready_i,
    output logic                     task_valid_o,
    output task_t                    task_o
);

    localparam int IDX_W = (NUM_MPQ > 1) ? $clog2(NUM_MPQ) : 1;

    logic [IDX_W-1:0] last_q;
    logic [IDX_W-1:0] pick_idx;
    logic             pick_found;
    logic             load;
    logic             valid_q;
    task_t            task_q;

    // search starts one past the last granted queue, which comes last
    always_comb begin
        int unsigned cand;
        pick_found = 1'b0;
        pick_idx   = last_q;
        for (int k = 1; k <= NUM_MPQ; k++) begin
            cand = (int'(last_q) + k) % NUM_MPQ;
            if (!pick_found && req_i[cand].valid) begin
                pick_found = 1'b1;
                pick_idx   = IDX_W'(cand);
            end
        end
    end

    // load when the register is empty or drains this cycle
    assign load = pick_found && (!valid_q || task_ready_i);

    // a grant tells the slice its task was taken
    always_comb begin
        grant_o = '0;
        if (load) begin
            grant_o[pick_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            last_q  <= IDX_W'(NUM_MPQ - 1);
        end else if (load) begin
            valid_q <= 1'b1;
            last_q  <= pick_idx;
        end else if (task_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    // held while stalled since load needs the register free
    always_ff @(posedge clk_i) begin
        if (load) begin
            task_q <= req_i[pick_idx].tsk;
        end
    end

    assign task_valid_o = valid_q;
    assign task_o       = task_q;

endmodule

// File: verilog/mpq_engine.sv
/* mpq engine top: her dispatch, per-queue slices, task scheduler */
module mpq_engine import mpq_pkg::*; #(
    parameter int NUM_MPQ    = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               her_valid_i,
    input  her_t               her_i,
    output logic               her_ready_o,
    input  logic               feedback_valid_i,
    input  logic [MSGID_W-1:0] feedback_msgid_i,
    input  logic               task_ready_i,
    output logic               task_valid_o,
    output task_t              task_o,
    output logic [NUM_MPQ-1:0] mpq_full_o
);

    logic [NUM_MPQ-1:0]       push;
    logic [NUM_MPQ-1:0]       feedback;
    logic [NUM_MPQ-1:0]       grant;
    slice_req_t [NUM_MPQ-1:0] slice_req;

    her_dispatch #(
        .NUM_MPQ (NUM_MPQ)
    ) u_her_dispatch (
        .her_valid_i      (her_valid_i),
        .her_i            (her_i),
        .her_ready_o      (her_ready_o),
        .feedback_valid_i (feedback_valid_i),
        .feedback_msgid_i (feedback_msgid_i),
        .full_i           (mpq_full_o),
        .push_o           (push),
        .feedback_o       (feedback)
    );

    for (genvar i = 0; i < NUM_MPQ; i++) begin : gen_slice
        mpq_slice #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_mpq_slice (
            .clk_i      (clk_i),
            .rst_ni     (rst_ni),
            .push_i     (push[i]),
            .her_i      (her_i),
            .feedback_i (feedback[i]),
            .grant_i    (grant[i]),
            .full_o     (mpq_full_o[i]),
            .req_o      (slice_req[i])
        );
    end

    task_scheduler #(
        .NUM_MPQ (NUM_MPQ)
    ) u_task_scheduler (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_i        (slice_req),
        .grant_o      (grant),
        .task_ready_i (task_ready_i),
        .task_valid_o (task_valid_o),
        .task_o       (task_o)
    );

endmodule

// File: dv/mpq_engine_props.sv
/* bound checks on mpq engine task output stability, reset state and her readiness */
module mpq_engine_props import mpq_pkg::*; #(
    parameter int NUM_MPQ = 8
) (
    input logic               clk_i,
    input logic               rst_ni,
    input her_t               her_i,
    input logic               her_ready_o,
    input logic               task_ready_i,
    input logic               task_valid_o,
    input task_t              task_o,
    input logic [NUM_MPQ-1:0] mpq_full_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IDX_W = (NUM_MPQ > 1) ? $clog2(NUM_MPQ) : 1;

    // a stalled task keeps both its valid and its contents
    stall_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        task_valid_o && !task_ready_i |=> task_valid_o && $stable(task_o))
        else $error("task output changed while stalled");

    reset_idle: assert property (@(posedge clk_i) $rose(rst_ni) |-> !task_valid_o)
        else $error("task valid high in the first cycle after reset");

    ready_follows_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        her_ready_o == !mpq_full_o[her_i.msgid[IDX_W-1:0]])
        else $error("her ready does not match the addressed queue full flag");

endmodule

bind mpq_engine mpq_engine_props #(
    .NUM_MPQ (NUM_MPQ)
) u_props (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .her_i        (her_i),
    .her_ready_o  (her_ready_o),
    .task_ready_i (task_ready_i),
    .task_valid_o (task_valid_o),
    .task_o       (task_o),
    .mpq_full_o   (mpq_full_o)
);

// File: dv/mpq_engine_tb.sv
/* mpq engine testbench: clock, reset, lcg stimulus, directed tests for the
   handler sequence, payload-only messages, back-pressure, full queue and round-robin */
module mpq_engine_tb import mpq_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_MPQ    = 8;
    localparam int FIFO_DEPTH = 4;
    // well above the few hundred cycles the tests take
    localparam int TIMEOUT_CYCLES = 4000;

    logic               clk_i;
    logic               rst_ni;
    logic               her_valid_i;
    her_t               her_i;
    logic               her_ready_o;
    logic               feedback_valid_i;
    logic [MSGID_W-1:0] feedback_msgid_i;
    logic               task_ready_i;
    logic               task_valid_o;
    task_t              task_o;
    logic [NUM_MPQ-1:0] mpq_full_o;

    logic [31:0] lcg_state;
    int          cycle_count = 0;
    // packets sent per message slot
    pkt_t        sent [2][FIFO_DEPTH];

    mpq_engine #(
        .NUM_MPQ    (NUM_MPQ),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .her_valid_i      (her_valid_i),
        .her_i            (her_i),
        .her_ready_o      (her_ready_o),
        .feedback_valid_i (feedback_valid_i),
        .feedback_msgid_i (feedback_msgid_i),
        .task_ready_i     (task_ready_i),
        .task_valid_o     (task_valid_o),
        .task_o           (task_o),
        .mpq_full_o       (mpq_full_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #2 clk_i = ~clk_i;
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
        end
        $display("timeout: the tests made no progress within %0d cycles", TIMEOUT_CYCLES);
        abort_run();
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // handler addresses must be nonzero to count as present
    function automatic logic [ADDR_W-1:0] rand_addr();
        return next_rand() | 32'h1;
    endfunction

    function automatic pkt_t rand_pkt();
        pkt_t        p;
        logic [31:0] r;
        p.pkt_addr = next_rand();
        r          = next_rand();
        p.pkt_size = r[31:16];
        return p;
    endfunction

    task automatic check_eq(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
        assert (got == exp) else begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic push_her(input her_t her);
        her_i       = her;
        her_valid_i = 1'b1;
        #1;
        while (!her_ready_o) begin
            next_cycle();
            #1;
        end
        next_cycle();
        her_valid_i = 1'b0;
    endtask

    // task_ready_i stays low for multi-packet messages so no task slips by
    task automatic send_message(input int slot, input logic [MSGID_W-1:0] msgid, input int n,
                                input logic [ADDR_W-1:0] hh, input logic [ADDR_W-1:0] ph,
                                input logic [ADDR_W-1:0] th);
        her_t her;
        for (int i = 0; i < n; i++) begin
            sent[slot][i] = rand_pkt();
            her           = '0;
            her.msgid     = msgid;
            her.eom       = (i == n - 1);
            her.pkt       = sent[slot][i];
            // later hers leave the handler fields at zero
            if (i == 0) begin
                her.hh_addr = hh;
                her.ph_addr = ph;
                her.th_addr = th;
            end
            push_her(her);
        end
    endtask

    task automatic send_feedback(input logic [MSGID_W-1:0] msgid);
        feedback_valid_i = 1'b1;
        feedback_msgid_i = msgid;
        next_cycle();
        feedback_valid_i = 1'b0;
    endtask

    // feedback goes out in the same cycle the task is taken
    task automatic expect_task(input logic [MSGID_W-1:0] msgid, input handler_kind_e kind,
                               input logic [ADDR_W-1:0] addr, input pkt_t pkt,
                               input bit give_fb);
        task_ready_i = 1'b1;
        while (!task_valid_o) begin
            next_cycle();
        end
        check_eq("task_o.msgid", task_o.msgid, msgid);
        check_eq("task_o.kind", task_o.kind, kind);
        check_eq("task_o.handler_addr", task_o.handler_addr, addr);
        check_eq("task_o.pkt", task_o.pkt, pkt);
        if (give_fb) begin
            send_feedback(msgid);
        end else begin
            next_cycle();
        end
    endtask

    task automatic check_after_reset();
        check_eq("task_valid_o", task_valid_o, 1'b0);
        check_eq("mpq_full_o", mpq_full_o, '0);
        check_eq("her_ready_o", her_ready_o, 1'b1);
    endtask

    task automatic full_handler_sequence();
        logic [ADDR_W-1:0] hh, ph, th;
        hh           = rand_addr();
        ph           = rand_addr();
        th           = rand_addr();
        task_ready_i = 1'b0;
        send_message(0, 8'h13, 3, hh, ph, th);
        expect_task(8'h13, HDR, hh, sent[0][0], 1'b1);
        for (int i = 0; i < 3; i++) begin
            expect_task(8'h13, PAY, ph, sent[0][i], 1'b1);
        end
        expect_task(8'h13, CMP, th, '0, 1'b1);
    endtask

    task automatic payload_only_message();
        logic [ADDR_W-1:0] ph, hh2, ph2, th2;
        ph           = rand_addr();
        hh2          = rand_addr();
        ph2          = rand_addr();
        th2          = rand_addr();
        task_ready_i = 1'b0;
        send_message(0, 8'h05, 2, '0, ph, '0);
        expect_task(8'h05, PAY, ph, sent[0][0], 1'b1);
        expect_task(8'h05, PAY, ph, sent[0][1], 1'b1);
        // a new message on the same queue brings its own handlers
        task_ready_i = 1'b0;
        send_message(1, 8'h0d, 1, hh2, ph2, th2);
        expect_task(8'h0d, HDR, hh2, sent[1][0], 1'b1);
        expect_task(8'h0d, PAY, ph2, sent[1][0], 1'b1);
        expect_task(8'h0d, CMP, th2, '0, 1'b1);
    endtask

    task automatic back_pressure_hold();
        task_t             held;
        logic [ADDR_W-1:0] ph;
        ph           = rand_addr();
        task_ready_i = 1'b0;
        send_message(0, 8'h44, 2, '0, ph, '0);
        // first payload task of the message is the one that must sit in the register
        held              = '0;
        held.msgid        = 8'h44;
        held.kind         = PAY;
        held.handler_addr = ph;
        held.pkt          = sent[0][0];
        while (!task_valid_o) begin
            next_cycle();
        end
        check_eq("task_o", task_o, held);
        repeat (6) begin
            next_cycle();
            check_eq("task_valid_o", task_valid_o, 1'b1);
            check_eq("task_o", task_o, held);
        end
        expect_task(8'h44, PAY, ph, sent[0][0], 1'b1);
        expect_task(8'h44, PAY, ph, sent[0][1], 1'b1);
        // nothing left over after release
        repeat (4) begin
            next_cycle();
            check_eq("task_valid_o", task_valid_o, 1'b0);
        end
    endtask

    task automatic full_queue_blocking();
        logic [ADDR_W-1:0] hh, ph, ph7;
        hh           = rand_addr();
        ph           = rand_addr();
        ph7          = rand_addr();
        task_ready_i = 1'b0;
        send_message(0, 8'h06, FIFO_DEPTH, hh, ph, '0);
        // header taken without feedback keeps the fifo full
        expect_task(8'h06, HDR, hh, sent[0][0], 1'b0);
        check_eq("mpq_full_o", mpq_full_o, NUM_MPQ'(1) << 6);
        her_i.msgid = 8'h06;
        #1;
        check_eq("her_ready_o", her_ready_o, 1'b0);
        next_cycle();
        her_i.msgid = 8'h07;
        #1;
        check_eq("her_ready_o", her_ready_o, 1'b1);
        next_cycle();
        send_message(1, 8'h07, 1, '0, ph7, '0);
        expect_task(8'h07, PAY, ph7, sent[1][0], 1'b1);
        send_feedback(8'h06);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            expect_task(8'h06, PAY, ph, sent[0][i], 1'b1);
        end
        check_eq("mpq_full_o", mpq_full_o, '0);
    endtask

    task automatic two_queue_alternation();
        logic [ADDR_W-1:0] ph_a, ph_b;
        ph_a         = rand_addr();
        ph_b         = rand_addr();
        task_ready_i = 1'b0;
        send_message(0, 8'h21, FIFO_DEPTH, '0, ph_a, '0);
        send_message(1, 8'h42, FIFO_DEPTH, '0, ph_b, '0);
        // queue 1 already holds the output register and round-robin alternates after it
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            expect_task(8'h21, PAY, ph_a, sent[0][i], 1'b1);
            expect_task(8'h42, PAY, ph_b, sent[1][i], 1'b1);
        end
    endtask

    initial begin
        lcg_state        = 32'd51;
        rst_ni           = 1'b0;
        her_valid_i      = 1'b0;
        her_i            = '0;
        feedback_valid_i = 1'b0;
        feedback_msgid_i = '0;
        task_ready_i     = 1'b0;
        repeat (5) begin
            @(posedge clk_i);
        end
        #1;
        rst_ni = 1'b1;
        check_after_reset();
        full_handler_sequence();
        payload_only_message();
        back_pressure_hold();
        full_queue_blocking();
        two_queue_alternation();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: vlog.f
verilog/mpq_pkg.sv
verilog/her_dispatch.sv
verilog/mpq_slice.sv
verilog/task_scheduler.sv
verilog/mpq_engine.sv
dv/mpq_engine_props.sv
dv/mpq_engine_tb.sv

// File: run.sh
#!/bin/sh
# build the mpq engine testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module mpq_engine_tb -f vlog.f -o sim_mpq_engine
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_mpq_engine
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi
exit 0
